/* sources.f */
+incdir+design
design/rv_pkg.sv
design/stage_ifs.sv
design/fetch_decode.sv
design/execute.sv
design/mem_wb.sv
design/hazard_unit.sv
design/rv32i.sv
verification/tb_clock.sv
verification/rv32i_tb.sv

/* run.sh */
#!/usr/bin/env bash

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal --top-module rv32i_tb \
    -f sources.f -o rv32i_sim
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

./obj_dir/rv32i_sim > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "All tests passed" sim.log; then
    exit 0
fi
echo "pass message not found in sim.log"
exit 1

/* verification/rv32i_tb.sv */
`include "rv_consts.svh"

module rv32i_tb;
    localparam int IMEM_DEPTH = 64;
    localparam int DMEM_DEPTH = 256;
    localparam int IMEM_AW    = $clog2(IMEM_DEPTH);
    localparam int DMEM_AW    = $clog2(DMEM_DEPTH);
    localparam int NSTORES    = 8;
    localparam int STORE_WAIT = 200;
    localparam logic [31:0] POISON_ADDR = 32'h0000_03f0;

    logic          clk;
    logic          rst_n;
    rv_pkg::word_t mem_addr_mem;
    rv_pkg::word_t mem_wdata_mem;
    logic          mem_write_mem;
    logic          mem_read_mem;
    rv_pkg::word_t mem_rdata_mem;
    rv_pkg::word_t current_pc;
    rv_pkg::word_t inst;
    logic          stall_pipl = 1'b0;
    logic          if_id_reg_en;

    rv_pkg::word_t imem [IMEM_DEPTH];
    rv_pkg::word_t dmem [DMEM_DEPTH];
    rv_pkg::word_t exp_addr [NSTORES];
    rv_pkg::word_t exp_data [NSTORES];
    rv_pkg::word_t exp_addr_now;
    rv_pkg::word_t exp_data_now;
    int            store_idx = 0;
    logic [31:0]   lcg_state = 32'h85a;
    logic          run_stalls = 1'b0;
    logic          store_acc;
    int            value_errs = 0;
    int            rule_errs = 0;
    int            timeout_errs = 0;

    tb_clock u_clock (
        .clk   (clk),
        .rst_n (rst_n)
    );

    rv32i dut0 (
        .clk           (clk),
        .rst_n         (rst_n),
        .mem_addr_mem  (mem_addr_mem),
        .mem_wdata_mem (mem_wdata_mem),
        .mem_write_mem (mem_write_mem),
        .mem_read_mem  (mem_read_mem),
        .mem_rdata_mem (mem_rdata_mem),
        .current_pc    (current_pc),
        .inst          (inst),
        .stall_pipl    (stall_pipl),
        .if_id_reg_en  (if_id_reg_en)
    );

    // both memories answer in the same cycle
    assign inst          = imem[current_pc[IMEM_AW+1:2]];
    assign mem_rdata_mem = dmem[mem_addr_mem[DMEM_AW+1:2]];
    assign store_acc     = mem_write_mem && !stall_pipl;
    assign exp_addr_now  = (store_idx < NSTORES) ? exp_addr[store_idx] : '0;
    assign exp_data_now  = (store_idx < NSTORES) ? exp_data[store_idx] : '0;

    function automatic rv_pkg::word_t r_type(input logic [6:0] f7, input rv_pkg::reg_idx_t rs2,
            input rv_pkg::reg_idx_t rs1, input logic [2:0] f3, input rv_pkg::reg_idx_t rd);
        return {f7, rs2, rs1, f3, rd, `RV_OP_REG};
    endfunction

    function automatic rv_pkg::word_t i_type(input logic [11:0] imm, input rv_pkg::reg_idx_t rs1,
            input logic [2:0] f3, input rv_pkg::reg_idx_t rd, input logic [6:0] op);
        return {imm, rs1, f3, rd, op};
    endfunction

    function automatic rv_pkg::word_t s_type(input logic [11:0] imm, input rv_pkg::reg_idx_t rs2,
            input rv_pkg::reg_idx_t rs1);
        return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], `RV_OP_STORE};
    endfunction

    function automatic rv_pkg::word_t b_type(input logic [12:0] imm, input rv_pkg::reg_idx_t rs2,
            input rv_pkg::reg_idx_t rs1, input logic [2:0] f3);
        return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], `RV_OP_BRANCH};
    endfunction

    function automatic rv_pkg::word_t u_type(input logic [19:0] imm, input rv_pkg::reg_idx_t rd);
        return {imm, rd, `RV_OP_LUI};
    endfunction

    function automatic rv_pkg::word_t j_type(input logic [20:0] imm, input rv_pkg::reg_idx_t rd);
        return {imm[20], imm[10:1], imm[11], imm[19:12], rd, `RV_OP_JAL};
    endfunction

    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    task automatic load_program();
        for (int i = 0; i < IMEM_DEPTH; i++) begin
            imem[i] = `RV_NOP;
        end
        // dependent ALU chain, no nops in between
        imem[0]  = i_type(12'd5, 5'd0, 3'b000, 5'd1, `RV_OP_IMM);
        imem[1]  = i_type(12'd7, 5'd1, 3'b000, 5'd2, `RV_OP_IMM);
        imem[2]  = r_type(7'h00, 5'd1, 5'd2, 3'b000, 5'd3);
        imem[3]  = r_type(7'h20, 5'd2, 5'd3, 3'b000, 5'd4);
        imem[4]  = s_type(12'h200, 5'd4, 5'd0);
        imem[5]  = r_type(7'h00, 5'd1, 5'd3, 3'b100, 5'd5);
        imem[6]  = r_type(7'h00, 5'd2, 5'd5, 3'b110, 5'd6);
        imem[7]  = r_type(7'h00, 5'd3, 5'd6, 3'b111, 5'd7);
        imem[8]  = s_type(12'h204, 5'd7, 5'd0);
        imem[9]  = r_type(7'h00, 5'd1, 5'd6, 3'b001, 5'd8);
        imem[10] = i_type(12'd2, 5'd8, 3'b101, 5'd9, `RV_OP_IMM);
        imem[11] = s_type(12'h208, 5'd9, 5'd0);
        imem[12] = i_type(12'hffd, 5'd0, 3'b000, 5'd10, `RV_OP_IMM);
        imem[13] = r_type(7'h00, 5'd1, 5'd10, 3'b010, 5'd11);
        imem[14] = s_type(12'h20c, 5'd11, 5'd0);
        imem[15] = u_type(20'habcde, 5'd12);
        imem[16] = i_type(12'h123, 5'd12, 3'b000, 5'd12, `RV_OP_IMM);
        imem[17] = s_type(12'h210, 5'd12, 5'd0);
        // load then immediate use
        imem[18] = i_type(12'h100, 5'd0, 3'b010, 5'd13, `RV_OP_LOAD);
        imem[19] = i_type(12'h011, 5'd13, 3'b000, 5'd14, `RV_OP_IMM);
        imem[20] = s_type(12'h214, 5'd14, 5'd0);
        // beq taken to 0x60, the two stores behind it must vanish
        imem[21] = b_type(13'd12, 5'd4, 5'd1, 3'b000);
        imem[22] = s_type(12'h3f0, 5'd1, 5'd0);
        imem[23] = s_type(12'h3f0, 5'd2, 5'd0);
        imem[24] = b_type(13'd8, 5'd4, 5'd1, 3'b001);
        imem[25] = i_type(12'h077, 5'd0, 3'b000, 5'd15, `RV_OP_IMM);
        imem[26] = s_type(12'h218, 5'd15, 5'd0);
        // jal to 0x78 with link 0x70
        imem[27] = j_type(21'd12, 5'd16);
        imem[28] = s_type(12'h3f0, 5'd1, 5'd0);
        imem[29] = s_type(12'h3f0, 5'd2, 5'd0);
        imem[30] = s_type(12'h21c, 5'd16, 5'd0);
        imem[31] = j_type(21'd0, 5'd0);
    endtask

    task automatic load_expected();
        for (int i = 0; i < DMEM_DEPTH; i++) begin
            dmem[i] = 32'hdead_0000 ^ (i << 2);
        end
        dmem[32'h100 >> 2] = 32'h1234_5678;
        for (int i = 0; i < NSTORES; i++) begin
            exp_addr[i] = 32'h200 + 32'(i * 4);
        end
        exp_data[0] = 32'h0000_0005;
        exp_data[1] = 32'h0000_0010;
        exp_data[2] = 32'h0000_00e0;
        exp_data[3] = 32'h0000_0001;
        exp_data[4] = 32'habcd_e123;
        exp_data[5] = 32'h1234_5689;
        exp_data[6] = 32'h0000_0077;
        exp_data[7] = 32'h0000_0070;
    endtask

    // roughly one stalled cycle in four
    always @(negedge clk) begin
        if (rst_n && run_stalls) begin
            lcg_state  = lcg_next(lcg_state);
            stall_pipl = (lcg_state[31:30] == 2'b00);
        end else begin
            stall_pipl = 1'b0;
        end
    end

    always @(posedge clk) begin
        if (rst_n && store_acc) begin
            dmem[mem_addr_mem[DMEM_AW+1:2]] <= mem_wdata_mem;
            store_idx <= store_idx + 1;
        end
    end

    a_reset_quiet: assert property (@(posedge clk)
        (!rst_n || !$past(rst_n)) |-> (!mem_write_mem && !mem_read_mem))
        else begin
            $display("** Error: mem_write_mem/mem_read_mem expected 0/0 got %h/%h",
                     $sampled(mem_write_mem), $sampled(mem_read_mem));
            value_errs++;
        end

    a_first_fetch: assert property (@(posedge clk)
        (rst_n && !$past(rst_n)) |-> (current_pc == `RV_RESET_PC && if_id_reg_en))
        else begin
            $display("** Error: current_pc expected %h got %h, if_id_reg_en expected 1 got %h",
                     `RV_RESET_PC, $sampled(current_pc), $sampled(if_id_reg_en));
            value_errs++;
        end

    a_store_addr: assert property (@(posedge clk) disable iff (!rst_n)
        (store_acc && store_idx < NSTORES) |-> (mem_addr_mem == exp_addr_now))
        else begin
            $display("** Error: mem_addr_mem store %0d expected %h got %h",
                     $sampled(store_idx), $sampled(exp_addr_now), $sampled(mem_addr_mem));
            value_errs++;
        end

    a_store_data: assert property (@(posedge clk) disable iff (!rst_n)
        (store_acc && store_idx < NSTORES) |-> (mem_wdata_mem == exp_data_now))
        else begin
            $display("** Error: mem_wdata_mem store %0d expected %h got %h",
                     $sampled(store_idx), $sampled(exp_data_now), $sampled(mem_wdata_mem));
            value_errs++;
        end

    a_no_extra_store: assert property (@(posedge clk) disable iff (!rst_n)
        store_acc |-> (store_idx < NSTORES))
        else begin
            $display("a store was accepted after the whole expected sequence had been seen");
            rule_errs++;
        end

    // flushed instructions would write here
    a_no_poison: assert property (@(posedge clk) disable iff (!rst_n)
        !(mem_write_mem && mem_addr_mem == POISON_ADDR))
        else begin
            $display("an instruction behind a taken branch or jump reached the data bus");
            rule_errs++;
        end

    a_stall_hold: assert property (@(posedge clk) disable iff (!rst_n)
        stall_pipl |=> (mem_addr_mem === $past(mem_addr_mem)
                        && mem_wdata_mem === $past(mem_wdata_mem)
                        && mem_write_mem === $past(mem_write_mem)
                        && current_pc === $past(current_pc)))
        else begin
            $display("the data bus or current_pc changed while stall_pipl was high");
            rule_errs++;
        end

    initial begin
        int  cycles;
        bit  timed_out;
        load_program();
        load_expected();
        timed_out = 1'b0;
        cycles = 0;
        while (!rst_n && cycles < 20) begin
            @(posedge clk);
            cycles++;
        end
        if (!rst_n) begin
            $display("reset was never released");
            timeout_errs++;
            timed_out = 1'b1;
        end
        run_stalls = 1'b1;
        for (int k = 0; k < NSTORES && !timed_out; k++) begin
            cycles = 0;
            while (store_idx <= k && cycles < STORE_WAIT) begin
                @(posedge clk);
                cycles++;
            end
            if (store_idx <= k) begin
                $display("store %0d to address %h never appeared on the data bus",
                         k, exp_addr[k]);
                timeout_errs++;
                timed_out = 1'b1;
            end
        end
        run_stalls = 1'b0;
        // let the jump loop spin to catch any late store
        repeat (20) @(posedge clk);
        $display("value errors %0d, rule errors %0d, timeouts %0d",
                 value_errs, rule_errs, timeout_errs);
        if (value_errs + rule_errs + timeout_errs == 0) begin
            $display("All tests passed");
        end else begin
            $display("Some tests failed");
        end
        $finish;
    end
endmodule

/* verification/tb_clock.sv */
module tb_clock (
    output logic clk,
    output logic rst_n
);
    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    // reset held for three rising edges, released on a falling edge
    initial begin
        rst_n = 1'b0;
        repeat (3) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;
    end
endmodule

/* design/rv32i.sv */
module rv32i (
    input  logic          clk,
    input  logic          rst_n,

    // data bus
    output rv_pkg::word_t mem_addr_mem,
    output rv_pkg::word_t mem_wdata_mem,
    output logic          mem_write_mem,
    output logic          mem_read_mem,
    input  rv_pkg::word_t mem_rdata_mem,

    // instruction fetch
    output rv_pkg::word_t current_pc,
    input  rv_pkg::word_t inst,

    // stall from the external bus
    input  logic          stall_pipl,
    output logic          if_id_reg_en
);
    rv_pkg::word_t    redirect_pc;
    rv_pkg::reg_idx_t wb_rd;
    rv_pkg::word_t    wb_data;
    logic             wb_we;

    id_exe_if  de_bus ();
    exe_mem_if em_bus ();
    hazard_if  hz_bus ();

    fetch_decode u_fetch_decode (
        .clk         (clk),
        .rst_n       (rst_n),
        .inst        (inst),
        .current_pc  (current_pc),
        .redirect_pc (redirect_pc),
        .wb_rd       (wb_rd),
        .wb_data     (wb_data),
        .wb_we       (wb_we),
        .de          (de_bus.source),
        .hz          (hz_bus.stage)
    );

    execute u_execute (
        .clk         (clk),
        .rst_n       (rst_n),
        .de          (de_bus.sink),
        .em          (em_bus.source),
        .wb_rd       (wb_rd),
        .wb_data     (wb_data),
        .wb_we       (wb_we),
        .redirect_pc (redirect_pc),
        .hz          (hz_bus.stage)
    );

    mem_wb u_mem_wb (
        .clk       (clk),
        .rst_n     (rst_n),
        .em        (em_bus.sink),
        .mem_addr  (mem_addr_mem),
        .mem_wdata (mem_wdata_mem),
        .mem_write (mem_write_mem),
        .mem_read  (mem_read_mem),
        .mem_rdata (mem_rdata_mem),
        .wb_rd     (wb_rd),
        .wb_data   (wb_data),
        .wb_we     (wb_we),
        .hz        (hz_bus.stage)
    );

    hazard_unit u_hazard_unit (
        .stall_pipl (stall_pipl),
        .hz         (hz_bus.control)
    );

    assign if_id_reg_en = hz_bus.if_id_en;

endmodule

/* design/hazard_unit.sv */
module hazard_unit (
    input logic        stall_pipl,
    hazard_if.control  hz
);
    logic load_use;

    // load in execute feeding the instruction in decode
    assign load_use = hz.exe_mem_read && (hz.exe_rd != '0) &&
                      ((hz.exe_rd == hz.id_rs1) || (hz.exe_rd == hz.id_rs2));

    // a bus stall freezes everything and suppresses clears
    assign hz.pc_en      = !stall_pipl && (hz.redirect || !load_use);
    assign hz.if_id_en   = !stall_pipl && !load_use;
    assign hz.if_id_clr  = !stall_pipl && hz.redirect;
    assign hz.id_exe_clr = !stall_pipl && (hz.redirect || load_use);
    assign hz.exe_en     = !stall_pipl;
    assign hz.mem_en     = !stall_pipl;

endmodule

/* design/mem_wb.sv */
module mem_wb (
    input  logic             clk,
    input  logic             rst_n,
    exe_mem_if.sink          em,
    output rv_pkg::word_t    mem_addr,
    output rv_pkg::word_t    mem_wdata,
    output logic             mem_write,
    output logic             mem_read,
    input  rv_pkg::word_t    mem_rdata,
    output rv_pkg::reg_idx_t wb_rd,
    output rv_pkg::word_t    wb_data,
    output logic             wb_we,
    hazard_if.stage          hz
);
    rv_pkg::word_t   wb_alu;
    rv_pkg::word_t   wb_load;
    rv_pkg::word_t   wb_link;
    rv_pkg::wb_sel_t wb_sel;

    // bus comes straight from EXE/MEM, so it holds while frozen
    assign mem_addr  = em.alu_res;
    assign mem_wdata = em.store_data;
    assign mem_write = em.mem_write;
    assign mem_read  = em.mem_read;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wb_we <= 1'b0;
            wb_rd <= '0;
        end else if (hz.mem_en) begin
            wb_we <= em.reg_write;
            wb_rd <= em.rd;
        end
    end

    always_ff @(posedge clk) begin
        if (hz.mem_en) begin
            wb_alu  <= em.alu_res;
            wb_load <= mem_rdata;
            wb_link <= em.pc_plus4;
            wb_sel  <= em.wb_sel;
        end
    end

    always_comb begin
        case (wb_sel)
            rv_pkg::WB_MEM: wb_data = wb_load;
            rv_pkg::WB_PC4: wb_data = wb_link;
            default:        wb_data = wb_alu;
        endcase
    end

    a_rd_wr_exclusive: assert property (@(posedge clk) disable iff (!rst_n)
        !(em.mem_write && em.mem_read));

endmodule

/* design/execute.sv */
module execute (
    input  logic             clk,
    input  logic             rst_n,
    id_exe_if.sink           de,
    exe_mem_if.source        em,
    input  rv_pkg::reg_idx_t wb_rd,
    input  rv_pkg::word_t    wb_data,
    input  logic             wb_we,
    output rv_pkg::word_t    redirect_pc,
    hazard_if.stage          hz
);
    rv_pkg::word_t mem_fwd;
    rv_pkg::word_t fwd_a;
    rv_pkg::word_t fwd_b;
    rv_pkg::word_t alu_b;
    rv_pkg::word_t alu_res;
    logic          taken;

    // a jal in the memory stage forwards its link address
    assign mem_fwd = (em.wb_sel == rv_pkg::WB_PC4) ? em.pc_plus4 : em.alu_res;

    // the younger producer wins
    always_comb begin
        if (em.reg_write && em.rd != '0 && em.rd == de.rs1) begin
            fwd_a = mem_fwd;
        end else if (wb_we && wb_rd != '0 && wb_rd == de.rs1) begin
            fwd_a = wb_data;
        end else begin
            fwd_a = de.op_a;
        end
        if (em.reg_write && em.rd != '0 && em.rd == de.rs2) begin
            fwd_b = mem_fwd;
        end else if (wb_we && wb_rd != '0 && wb_rd == de.rs2) begin
            fwd_b = wb_data;
        end else begin
            fwd_b = de.op_b;
        end
    end

    assign alu_b = de.use_imm ? de.imm : fwd_b;

    always_comb begin
        case (de.alu_op)
            rv_pkg::ALU_SUB:    alu_res = fwd_a - alu_b;
            rv_pkg::ALU_AND:    alu_res = fwd_a & alu_b;
            rv_pkg::ALU_OR:     alu_res = fwd_a | alu_b;
            rv_pkg::ALU_XOR:    alu_res = fwd_a ^ alu_b;
            rv_pkg::ALU_SLT:    alu_res = {31'b0, ($signed(fwd_a) < $signed(alu_b))};
            rv_pkg::ALU_SLL:    alu_res = fwd_a << alu_b[4:0];
            rv_pkg::ALU_SRL:    alu_res = fwd_a >> alu_b[4:0];
            rv_pkg::ALU_PASS_B: alu_res = alu_b;
            default:            alu_res = fwd_a + alu_b;
        endcase
    end

    // beq and bne compare the forwarded registers
    assign taken       = de.branch && (de.branch_ne ? (fwd_a != fwd_b) : (fwd_a == fwd_b));
    assign hz.redirect = taken || de.jump;
    assign redirect_pc = de.pc + de.imm;

    assign hz.exe_rd       = de.rd;
    assign hz.exe_mem_read = de.mem_read;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            em.reg_write <= 1'b0;
            em.mem_read  <= 1'b0;
            em.mem_write <= 1'b0;
        end else if (hz.mem_en) begin
            em.reg_write <= de.reg_write;
            em.mem_read  <= de.mem_read;
            em.mem_write <= de.mem_write;
        end
    end

    always_ff @(posedge clk) begin
        if (hz.mem_en) begin
            em.alu_res    <= alu_res;
            em.store_data <= fwd_b;
            em.rd         <= de.rd;
            em.wb_sel     <= de.wb_sel;
            em.pc_plus4   <= de.pc + 32'd4;
        end
    end

    // the slot behind a taken redirect is flushed, so it cannot redirect again
    a_no_redirect_from_bubble: assert property (@(posedge clk) disable iff (!rst_n)
        (hz.redirect && hz.mem_en) |=> !hz.redirect);

endmodule

/* design/fetch_decode.sv */
`include "rv_consts.svh"

module fetch_decode (
    input  logic             clk,
    input  logic             rst_n,
    input  rv_pkg::word_t    inst,
    output rv_pkg::word_t    current_pc,
    input  rv_pkg::word_t    redirect_pc,
    input  rv_pkg::reg_idx_t wb_rd,
    input  rv_pkg::word_t    wb_data,
    input  logic             wb_we,
    id_exe_if.source         de,
    hazard_if.stage          hz
);
    rv_pkg::word_t    pc;
    rv_pkg::word_t    if_id_inst;
    rv_pkg::word_t    if_id_pc;
    rv_pkg::word_t    regs [32];
    logic [6:0]       opcode;
    logic [2:0]       funct3;
    rv_pkg::reg_idx_t rs1;
    rv_pkg::reg_idx_t rs2;
    rv_pkg::reg_idx_t rd;
    rv_pkg::word_t    rs1_val;
    rv_pkg::word_t    rs2_val;
    rv_pkg::word_t    imm;
    rv_pkg::alu_t     alu_f3;
    rv_pkg::alu_t     alu_op;
    rv_pkg::wb_sel_t  wb_sel;
    logic             use_imm;
    logic             reg_write;
    logic             mem_read;
    logic             mem_write;
    logic             branch;
    logic             jump;

    assign current_pc = pc;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            pc <= `RV_RESET_PC;
        end else if (hz.pc_en) begin
            pc <= hz.redirect ? redirect_pc : pc + 32'd4;
        end
    end

    // IF/ID, a flushed slot turns into a nop
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            if_id_inst <= `RV_NOP;
            if_id_pc   <= `RV_RESET_PC;
        end else if (hz.if_id_clr) begin
            if_id_inst <= `RV_NOP;
        end else if (hz.if_id_en) begin
            if_id_inst <= inst;
            if_id_pc   <= pc;
        end
    end

    assign opcode = if_id_inst[6:0];
    assign funct3 = if_id_inst[14:12];
    assign rs1    = if_id_inst[19:15];
    assign rs2    = if_id_inst[24:20];
    assign rd     = if_id_inst[11:7];

    assign hz.id_rs1 = rs1;
    assign hz.id_rs2 = rs2;

    always_comb begin
        case (funct3)
            3'b000: begin
                // bit 30 picks sub, only for the register form
                alu_f3 = (opcode == `RV_OP_REG && if_id_inst[30]) ? rv_pkg::ALU_SUB
                                                                  : rv_pkg::ALU_ADD;
            end
            3'b001:  alu_f3 = rv_pkg::ALU_SLL;
            3'b010:  alu_f3 = rv_pkg::ALU_SLT;
            3'b100:  alu_f3 = rv_pkg::ALU_XOR;
            3'b101:  alu_f3 = rv_pkg::ALU_SRL;
            3'b110:  alu_f3 = rv_pkg::ALU_OR;
            3'b111:  alu_f3 = rv_pkg::ALU_AND;
            default: alu_f3 = rv_pkg::ALU_ADD;
        endcase
    end

    always_comb begin
        imm       = {{20{if_id_inst[31]}}, if_id_inst[31:20]};
        alu_op    = rv_pkg::ALU_ADD;
        wb_sel    = rv_pkg::WB_ALU;
        use_imm   = 1'b1;
        reg_write = 1'b0;
        mem_read  = 1'b0;
        mem_write = 1'b0;
        branch    = 1'b0;
        jump      = 1'b0;
        case (opcode)
            `RV_OP_REG: begin
                alu_op    = alu_f3;
                use_imm   = 1'b0;
                reg_write = 1'b1;
            end
            `RV_OP_IMM: begin
                alu_op    = alu_f3;
                reg_write = 1'b1;
            end
            `RV_OP_LUI: begin
                imm       = {if_id_inst[31:12], 12'b0};
                alu_op    = rv_pkg::ALU_PASS_B;
                reg_write = 1'b1;
            end
            `RV_OP_LOAD: begin
                wb_sel    = rv_pkg::WB_MEM;
                reg_write = 1'b1;
                mem_read  = 1'b1;
            end
            `RV_OP_STORE: begin
                imm       = {{20{if_id_inst[31]}}, if_id_inst[31:25], if_id_inst[11:7]};
                mem_write = 1'b1;
            end
            `RV_OP_BRANCH: begin
                imm     = {{19{if_id_inst[31]}}, if_id_inst[31], if_id_inst[7],
                           if_id_inst[30:25], if_id_inst[11:8], 1'b0};
                use_imm = 1'b0;
                branch  = 1'b1;
            end
            `RV_OP_JAL: begin
                imm       = {{11{if_id_inst[31]}}, if_id_inst[31], if_id_inst[19:12],
                             if_id_inst[20], if_id_inst[30:21], 1'b0};
                wb_sel    = rv_pkg::WB_PC4;
                reg_write = 1'b1;
                jump      = 1'b1;
            end
            // anything unsupported leaves a bubble
            default: use_imm = 1'b1;
        endcase
    end

    // register file, writeback is seen by decode in the same cycle
    always_ff @(posedge clk) begin
        if (wb_we && wb_rd != '0) begin
            regs[wb_rd] <= wb_data;
        end
    end

    assign rs1_val = (rs1 == '0) ? '0 : (wb_we && wb_rd == rs1) ? wb_data : regs[rs1];
    assign rs2_val = (rs2 == '0) ? '0 : (wb_we && wb_rd == rs2) ? wb_data : regs[rs2];

    // ID/EXE control
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            de.reg_write <= 1'b0;
            de.mem_read  <= 1'b0;
            de.mem_write <= 1'b0;
            de.branch    <= 1'b0;
            de.jump      <= 1'b0;
        end else if (hz.id_exe_clr) begin
            de.reg_write <= 1'b0;
            de.mem_read  <= 1'b0;
            de.mem_write <= 1'b0;
            de.branch    <= 1'b0;
            de.jump      <= 1'b0;
        end else if (hz.exe_en) begin
            de.reg_write <= reg_write;
            de.mem_read  <= mem_read;
            de.mem_write <= mem_write;
            de.branch    <= branch;
            de.jump      <= jump;
        end
    end

    // ID/EXE payload
    always_ff @(posedge clk) begin
        if (hz.exe_en) begin
            de.pc        <= if_id_pc;
            de.rs1       <= rs1;
            de.rs2       <= rs2;
            de.rd        <= rd;
            de.op_a      <= rs1_val;
            de.op_b      <= rs2_val;
            de.imm       <= imm;
            de.alu_op    <= alu_op;
            de.use_imm   <= use_imm;
            de.branch_ne <= funct3[0];
            de.wb_sel    <= wb_sel;
        end
    end

    // fetch stays word aligned, also after a redirect
    a_pc_aligned: assert property (@(posedge clk) disable iff (!rst_n)
        pc[1:0] == 2'b00);

endmodule

/* design/stage_ifs.sv */
// decoded instruction handed from decode to execute
interface id_exe_if;
    rv_pkg::word_t    pc;
    rv_pkg::reg_idx_t rs1;
    rv_pkg::reg_idx_t rs2;
    rv_pkg::reg_idx_t rd;
    rv_pkg::word_t    op_a;
    rv_pkg::word_t    op_b;
    rv_pkg::word_t    imm;
    rv_pkg::alu_t     alu_op;
    logic             use_imm;
    logic             reg_write;
    logic             mem_read;
    logic             mem_write;
    logic             branch;
    logic             branch_ne;
    logic             jump;
    rv_pkg::wb_sel_t  wb_sel;

    modport source (output pc, rs1, rs2, rd, op_a, op_b, imm, alu_op, use_imm,
                    reg_write, mem_read, mem_write, branch, branch_ne, jump, wb_sel);
    modport sink   (input pc, rs1, rs2, rd, op_a, op_b, imm, alu_op, use_imm,
                    reg_write, mem_read, mem_write, branch, branch_ne, jump, wb_sel);
endinterface

interface exe_mem_if;
    rv_pkg::word_t    alu_res;
    rv_pkg::word_t    store_data;
    rv_pkg::reg_idx_t rd;
    logic             reg_write;
    logic             mem_read;
    logic             mem_write;
    rv_pkg::wb_sel_t  wb_sel;
    rv_pkg::word_t    pc_plus4;

    modport source (output alu_res, store_data, rd, reg_write, mem_read, mem_write,
                    wb_sel, pc_plus4);
    modport sink   (input alu_res, store_data, rd, reg_write, mem_read, mem_write,
                    wb_sel, pc_plus4);
endinterface

// enables and clears go to the stages, status comes back
interface hazard_if;
    logic             pc_en;
    logic             if_id_en;
    logic             if_id_clr;
    logic             id_exe_clr;
    logic             exe_en;
    logic             mem_en;
    rv_pkg::reg_idx_t id_rs1;
    rv_pkg::reg_idx_t id_rs2;
    rv_pkg::reg_idx_t exe_rd;
    logic             exe_mem_read;
    logic             redirect;

    modport control (output pc_en, if_id_en, if_id_clr, id_exe_clr, exe_en, mem_en,
                     input id_rs1, id_rs2, exe_rd, exe_mem_read, redirect);
    modport stage   (input pc_en, if_id_en, if_id_clr, id_exe_clr, exe_en, mem_en,
                     output id_rs1, id_rs2, exe_rd, exe_mem_read, redirect);
endinterface

/* design/rv_pkg.sv */
package rv_pkg;

    typedef logic [31:0] word_t;
    typedef logic [4:0]  reg_idx_t;

    // operations the execute stage can perform
    typedef enum logic [3:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_XOR,
        ALU_SLT,
        ALU_SLL,
        ALU_SRL,
        ALU_PASS_B
    } alu_t;

    // source of the value written back to the register file
    typedef enum logic [1:0] {
        WB_ALU,
        WB_MEM,
        WB_PC4
    } wb_sel_t;

endpackage

/* design/rv_consts.svh */
`ifndef RV_CONSTS_SVH
`define RV_CONSTS_SVH

`define RV_RESET_PC   32'h0000_0000

`define RV_OP_REG     7'b0110011
`define RV_OP_IMM     7'b0010011
`define RV_OP_LUI     7'b0110111
`define RV_OP_LOAD    7'b0000011
`define RV_OP_STORE   7'b0100011
`define RV_OP_BRANCH  7'b1100011
`define RV_OP_JAL     7'b1101111

// addi x0, x0, 0
`define RV_NOP        32'h0000_0013

`endif
